/* Makefile */
# Verilator build and run for the RV32I decode stage

VERILATOR ?= verilator
TOP       ?= decodeTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIMBIN = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(SIMBIN) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* design/ctrlDecoder.sv */
module ctrlDecoder #(
	parameter int QueueDepth = 4
) (
	input  logic                   clk,
	input  logic                   arstN,
	input  logic                   instrValid,
	input  decodePkg::instrT       instr,
	input  logic                   credit,
	output logic                   instrCredit,
	output logic                   push,
	output decodePkg::decodeEntryT entry
);
	import decodePkg::*;

	instrT                 holdInstr;
	logic                  holdValid;
	logic [CreditBits-1:0] qCredits;
	logic                  sendNow;
	decodeEntryT           decoded;
	logic                  legal;
	logic [6:0]            opcode;
	logic [2:0]            funct3;
	wordT                  immI;
	wordT                  immS;
	wordT                  immB;
	wordT                  immU;
	wordT                  immJ;
	wordT                  shamt;

	assign opcode = holdInstr[6:0];
	assign funct3 = holdInstr[14:12];

	assign immI = {{20{holdInstr[31]}}, holdInstr[31:20]};
	assign immS = {{20{holdInstr[31]}}, holdInstr[31:25], holdInstr[11:7]};
	assign immB = {{19{holdInstr[31]}}, holdInstr[31], holdInstr[7], holdInstr[30:25],
		holdInstr[11:8], 1'b0};
	assign immU = {holdInstr[31:12], 12'b0};
	assign immJ = {{11{holdInstr[31]}}, holdInstr[31], holdInstr[19:12], holdInstr[20],
		holdInstr[30:21], 1'b0};
	assign shamt = {27'b0, holdInstr[24:20]};

	//////////////////////////////////////////////////
	// decode of the held instruction
	//////////////////////////////////////////////////
	always_comb begin
		decoded = '0;
		decoded.aluOp = Add;
		decoded.loadType = LoadWordOrNone;
		decoded.instrClass = ClassAlu;
		decoded.rs1 = holdInstr[19:15];
		decoded.rd = holdInstr[11:7];
		legal = 1'b1;
		case (opcode)
			OpLui, OpAuipc: begin
				decoded.rs1 = '0;
				decoded.imm = immU;
				decoded.regWrite = 1'b1;
				decoded.aluSrc = 1'b1;
				decoded.auipc = (opcode == OpAuipc);
			end
			OpJal: begin
				decoded.rs1 = '0;
				decoded.imm = immJ;
				decoded.regWrite = 1'b1;
				decoded.aluSrc = 1'b1;
				decoded.jump = 1'b1;
			end
			OpJalr: begin
				decoded.imm = immI;
				decoded.regWrite = 1'b1;
				decoded.aluSrc = 1'b1;
				decoded.jalr = 1'b1;
				legal = (funct3 == 3'b000);
			end
			OpBranch: begin
				decoded.rd = '0;
				decoded.rs2 = holdInstr[24:20];
				decoded.imm = immB;
				decoded.branch = 1'b1;
				decoded.instrClass = ClassBranch;
				case (funct3)
					3'b000: decoded.aluOp = Beq;
					3'b001: decoded.aluOp = Bne;
					3'b100: decoded.aluOp = Blt;
					3'b101: decoded.aluOp = Bge;
					3'b110: decoded.aluOp = Bltu;
					3'b111: decoded.aluOp = Bgeu;
					default: legal = 1'b0;
				endcase
			end
			OpLoad: begin
				decoded.imm = immI;
				decoded.regWrite = 1'b1;
				decoded.aluSrc = 1'b1;
				decoded.memToReg = 1'b1;
				decoded.instrClass = ClassLoad;
				case (funct3)
					3'b000: decoded.loadType = LoadByte;
					3'b001: decoded.loadType = LoadHalf;
					3'b010: decoded.loadType = LoadWordOrNone;
					3'b100: decoded.loadType = LoadByteU;
					3'b101: decoded.loadType = LoadHalfU;
					default: legal = 1'b0;
				endcase
			end
			OpStore: begin
				decoded.rd = '0;
				decoded.rs2 = holdInstr[24:20];
				decoded.imm = immS;
				decoded.aluSrc = 1'b1;
				decoded.memWrite = 1'b1;
				decoded.instrClass = ClassStore;
				case (funct3)
					3'b000: decoded.storeMask = 2'd1;
					3'b001: decoded.storeMask = 2'd2;
					3'b010: decoded.storeMask = 2'd3;
					default: legal = 1'b0;
				endcase
			end
			OpImm: begin
				decoded.imm = immI;
				decoded.regWrite = 1'b1;
				decoded.aluSrc = 1'b1;
				case (funct3)
					3'b000: decoded.aluOp = Add;
					3'b010: decoded.aluOp = Slti;
					3'b011: decoded.aluOp = Sltiu;
					3'b100: decoded.aluOp = Xori;
					3'b110: decoded.aluOp = Ori;
					3'b111: decoded.aluOp = Andi;
					3'b001: begin
						decoded.aluOp = Slli;
						decoded.imm = shamt;
					end
					default: begin // 101, bit 30 picks arithmetic
						decoded.aluOp = holdInstr[30] ? Srai : Srli;
						decoded.imm = shamt;
					end
				endcase
			end
			OpReg: begin
				decoded.rs2 = holdInstr[24:20];
				decoded.regWrite = 1'b1;
				case (funct3)
					3'b000: decoded.aluOp = holdInstr[30] ? Sub : AddR;
					3'b001: decoded.aluOp = Sll;
					3'b010: decoded.aluOp = Slt;
					3'b011: decoded.aluOp = Sltu;
					3'b100: decoded.aluOp = Xor;
					3'b101: decoded.aluOp = holdInstr[30] ? Sra : Srl;
					3'b110: decoded.aluOp = Or;
					default: decoded.aluOp = And;
				endcase
			end
			OpFence, OpSystem: begin
				decoded.instrClass = ClassSystem;
				if (opcode == OpFence)
					decoded.aluOp = Nop;
				else
					decoded.aluOp = holdInstr[20] ? Ebreak : Ecall;
				legal = (funct3 == 3'b000);
			end
			default: legal = 1'b0;
		endcase
		if (!legal)
			decoded = IllegalEntry;
	end

	//////////////////////////////////////////////////
	// holding register and queue credits
	//////////////////////////////////////////////////
	assign sendNow = holdValid && (qCredits != '0);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			holdValid <= 1'b0;
			push <= 1'b0;
			instrCredit <= 1'b0;
			qCredits <= CreditBits'(QueueDepth);
		end else begin
			push <= sendNow;
			instrCredit <= sendNow; // slot freed, upstream may send again
			if (instrValid)
				holdValid <= 1'b1;
			else if (sendNow)
				holdValid <= 1'b0;
			case ({sendNow, credit})
				2'b10: qCredits <= qCredits - 1'b1;
				2'b01: qCredits <= qCredits + 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid)
			holdInstr <= instr;
		if (sendNow)
			entry <= decoded;
	end

endmodule

/* design/decodePkg.sv */
package decodePkg;

	//////////////////////////////////////////////////
	// basic widths
	//////////////////////////////////////////////////
	typedef logic [31:0] instrT;
	typedef logic [31:0] wordT;
	typedef logic [4:0]  regIdxT;
	typedef logic [1:0]  storeMaskT; // 0 none, 1 byte, 2 half, 3 word

	localparam int CreditBits = 4;

	//////////////////////////////////////////////////
	// control encodings
	//////////////////////////////////////////////////
	typedef enum logic [6:0] {
		Beq = 7'd0, Bne = 7'd1, Blt = 7'd2, Bge = 7'd3, Bltu = 7'd4, Bgeu = 7'd5,
		Add = 7'd18,
		Slti = 7'd19, Sltiu = 7'd20, Xori = 7'd21, Ori = 7'd22, Andi = 7'd23,
		Slli = 7'd24, Srli = 7'd25, Srai = 7'd26,
		AddR = 7'd27, Sub = 7'd28, Sll = 7'd29, Slt = 7'd30, Sltu = 7'd31,
		Xor = 7'd32, Srl = 7'd33, Sra = 7'd34, Or = 7'd35, And = 7'd36,
		Nop = 7'd37, Ecall = 7'd38, Ebreak = 7'd39
	} aluOpT;

	typedef enum logic [2:0] {
		LoadByte = 3'd1,
		LoadHalf = 3'd2,
		LoadByteU = 3'd3,
		LoadHalfU = 3'd4,
		LoadWordOrNone = 3'd5 // also every non-load
	} loadTypeT;

	typedef enum logic [2:0] {
		ClassAlu = 3'd0,
		ClassBranch = 3'd1,
		ClassLoad = 3'd2,
		ClassStore = 3'd3,
		ClassSystem = 3'd4
	} instrClassT;

	localparam logic [6:0] OpLui = 7'b0110111;
	localparam logic [6:0] OpAuipc = 7'b0010111;
	localparam logic [6:0] OpJal = 7'b1101111;
	localparam logic [6:0] OpJalr = 7'b1100111;
	localparam logic [6:0] OpBranch = 7'b1100011;
	localparam logic [6:0] OpLoad = 7'b0000011;
	localparam logic [6:0] OpStore = 7'b0100011;
	localparam logic [6:0] OpImm = 7'b0010011;
	localparam logic [6:0] OpReg = 7'b0110011;
	localparam logic [6:0] OpFence = 7'b0001111;
	localparam logic [6:0] OpSystem = 7'b1110011;

	//////////////////////////////////////////////////
	// decoded control word
	//////////////////////////////////////////////////
	typedef struct packed {
		aluOpT      aluOp;
		wordT       imm;
		regIdxT     rs1;
		regIdxT     rs2;
		regIdxT     rd;
		logic       regWrite;
		logic       aluSrc;
		logic       memToReg;
		logic       memWrite;
		logic       branch;
		logic       jump;
		logic       jalr;
		logic       auipc;
		loadTypeT   loadType;
		storeMaskT  storeMask;
		instrClassT instrClass;
		logic       illegal;
	} decodeEntryT;

	// word for any undefined encoding
	localparam decodeEntryT IllegalEntry = '{
		aluOp: Nop,
		loadType: LoadWordOrNone,
		instrClass: ClassSystem,
		illegal: 1'b1,
		default: '0
	};

endpackage

/* design/decodeQueue.sv */
module decodeQueue #(
	parameter int QueueDepth = 4
) (
	input  logic                   clk,
	input  logic                   arstN,
	input  logic                   push,
	input  decodePkg::decodeEntryT entry,
	input  logic                   pop,
	output logic                   credit,
	output logic                   headValid,
	output decodePkg::decodeEntryT head
);
	import decodePkg::*;

	localparam int PtrBits = $clog2(QueueDepth);
	localparam int CntBits = $clog2(QueueDepth + 1);

	decodeEntryT        mem [QueueDepth];
	logic [PtrBits-1:0] wrPtr;
	logic [PtrBits-1:0] rdPtr;
	logic [CntBits-1:0] count;

	function automatic logic [PtrBits-1:0] nextPtr(logic [PtrBits-1:0] p);
		return (p == PtrBits'(QueueDepth - 1)) ? '0 : p + 1'b1; // depth need not be 2^n
	endfunction

	assign headValid = (count != '0);
	assign head = mem[rdPtr];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			credit <= pop; // one slot back to the producer
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= entry;
	end

endmodule

/* design/decodeTop.sv */
module decodeTop #(
	parameter int QueueDepth = 4,
	parameter int OutCredits = 2
) (
	input  logic                  clk,
	input  logic                  arstN,
	input  logic                  instrValid,
	input  decodePkg::instrT      instr,
	input  logic                  outCredit,
	output logic                  instrCredit,
	output logic                  decValid,
	output decodePkg::aluOpT      decAluOp,
	output decodePkg::wordT       decImm,
	output decodePkg::regIdxT     decRs1,
	output decodePkg::regIdxT     decRs2,
	output decodePkg::regIdxT     decRd,
	output logic                  decRegWrite,
	output logic                  decAluSrc,
	output logic                  decMemToReg,
	output logic                  decMemWrite,
	output logic                  decBranch,
	output logic                  decJump,
	output logic                  decJalr,
	output logic                  decAuipc,
	output decodePkg::loadTypeT   decLoadType,
	output decodePkg::storeMaskT  decStoreMask,
	output decodePkg::instrClassT decClass,
	output logic                  decIllegal
);
	import decodePkg::*;

	logic        push;
	logic        qCredit;
	logic        pop;
	logic        headValid;
	decodeEntryT entry;
	decodeEntryT head;

	ctrlDecoder #(.QueueDepth(QueueDepth)) i_ctrlDecoder (
		.clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr),
		.credit(qCredit), .instrCredit(instrCredit), .push(push), .entry(entry)
	);

	decodeQueue #(.QueueDepth(QueueDepth)) i_decodeQueue (
		.clk(clk), .arstN(arstN), .push(push), .entry(entry), .pop(pop),
		.credit(qCredit), .headValid(headValid), .head(head)
	);

	issuePort #(.OutCredits(OutCredits)) i_issuePort (
		.clk(clk), .arstN(arstN), .headValid(headValid), .head(head),
		.outCredit(outCredit), .pop(pop), .decValid(decValid),
		.decAluOp(decAluOp), .decImm(decImm), .decRs1(decRs1), .decRs2(decRs2),
		.decRd(decRd), .decRegWrite(decRegWrite), .decAluSrc(decAluSrc),
		.decMemToReg(decMemToReg), .decMemWrite(decMemWrite), .decBranch(decBranch),
		.decJump(decJump), .decJalr(decJalr), .decAuipc(decAuipc),
		.decLoadType(decLoadType), .decStoreMask(decStoreMask),
		.decClass(decClass), .decIllegal(decIllegal)
	);

endmodule

/* design/issuePort.sv */
module issuePort #(
	parameter int OutCredits = 2
) (
	input  logic                   clk,
	input  logic                   arstN,
	input  logic                   headValid,
	input  decodePkg::decodeEntryT head,
	input  logic                   outCredit,
	output logic                   pop,
	output logic                   decValid,
	output decodePkg::aluOpT       decAluOp,
	output decodePkg::wordT        decImm,
	output decodePkg::regIdxT      decRs1,
	output decodePkg::regIdxT      decRs2,
	output decodePkg::regIdxT      decRd,
	output logic                   decRegWrite,
	output logic                   decAluSrc,
	output logic                   decMemToReg,
	output logic                   decMemWrite,
	output logic                   decBranch,
	output logic                   decJump,
	output logic                   decJalr,
	output logic                   decAuipc,
	output decodePkg::loadTypeT    decLoadType,
	output decodePkg::storeMaskT   decStoreMask,
	output decodePkg::instrClassT  decClass,
	output logic                   decIllegal
);
	import decodePkg::*;

	logic [CreditBits-1:0] outCnt;
	decodeEntryT           outEntry;

	assign pop = headValid && (outCnt != '0); // issue and pop are the same event

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decValid <= 1'b0;
			outCnt <= CreditBits'(OutCredits);
		end else begin
			decValid <= pop;
			case ({pop, outCredit})
				2'b10: outCnt <= outCnt - 1'b1;
				2'b01: outCnt <= outCnt + 1'b1;
				default: ; // both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop)
			outEntry <= head;
	end

	assign decAluOp = outEntry.aluOp;
	assign decImm = outEntry.imm;
	assign decRs1 = outEntry.rs1;
	assign decRs2 = outEntry.rs2;
	assign decRd = outEntry.rd;
	assign decRegWrite = outEntry.regWrite;
	assign decAluSrc = outEntry.aluSrc;
	assign decMemToReg = outEntry.memToReg;
	assign decMemWrite = outEntry.memWrite;
	assign decBranch = outEntry.branch;
	assign decJump = outEntry.jump;
	assign decJalr = outEntry.jalr;
	assign decAuipc = outEntry.auipc;
	assign decLoadType = outEntry.loadType;
	assign decStoreMask = outEntry.storeMask;
	assign decClass = outEntry.instrClass;
	assign decIllegal = outEntry.illegal;

endmodule

/* include/decodeExpect.svh */
`ifndef DECODE_EXPECT_SVH
`define DECODE_EXPECT_SVH

// included inside a module body after import decodePkg::*

//////////////////////////////////////////////////
// reference model, one field at a time
//////////////////////////////////////////////////
function automatic logic expectLegal(instrT i);
	logic [2:0] f3;
	f3 = i[14:12];
	case (i[6:0])
		OpLui, OpAuipc, OpJal, OpImm, OpReg: return 1'b1;
		OpJalr, OpFence, OpSystem: return f3 == 3'b000;
		OpBranch: return !(f3 inside {3'b010, 3'b011});
		OpLoad: return f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
		OpStore: return f3 <= 3'b010;
		default: return 1'b0;
	endcase
endfunction

function automatic aluOpT expectAluOp(instrT i);
	aluOpT brOps [8];
	aluOpT immOps [8];
	aluOpT regOps [8];
	logic [2:0] f3;
	brOps = '{Beq, Bne, Nop, Nop, Blt, Bge, Bltu, Bgeu};
	immOps = '{Add, Slli, Slti, Sltiu, Xori, Srli, Ori, Andi};
	regOps = '{AddR, Sll, Slt, Sltu, Xor, Srl, Or, And};
	f3 = i[14:12];
	case (i[6:0])
		OpBranch: return brOps[f3];
		OpImm: return (f3 == 3'b101 && i[30]) ? Srai : immOps[f3];
		OpReg: begin
			if (i[30] && f3 == 3'b000)
				return Sub;
			return (i[30] && f3 == 3'b101) ? Sra : regOps[f3];
		end
		OpFence: return Nop;
		OpSystem: return i[20] ? Ebreak : Ecall;
		default: return Add;
	endcase
endfunction

function automatic wordT expectImm(instrT i);
	logic [2:0] f3;
	f3 = i[14:12];
	case (i[6:0])
		OpLui, OpAuipc: return {i[31:12], 12'b0};
		OpJal: return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
		OpJalr, OpLoad: return {{20{i[31]}}, i[31:20]};
		OpBranch: return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
		OpStore: return {{20{i[31]}}, i[31:25], i[11:7]};
		OpImm: begin
			if (f3 == 3'b001 || f3 == 3'b101)
				return {27'b0, i[24:20]};
			return {{20{i[31]}}, i[31:20]};
		end
		default: return '0;
	endcase
endfunction

function automatic decodeEntryT expectEntry(instrT i);
	decodeEntryT e;
	loadTypeT    ldTypes [8];
	logic [6:0]  op;
	logic [2:0]  f3;
	ldTypes = '{LoadByte, LoadHalf, LoadWordOrNone, LoadWordOrNone,
		LoadByteU, LoadHalfU, LoadWordOrNone, LoadWordOrNone};
	op = i[6:0];
	f3 = i[14:12];
	e = '0;
	if (!expectLegal(i)) begin
		// nop, no flags, zero imm and indices, system class
		e.aluOp = Nop;
		e.loadType = LoadWordOrNone;
		e.instrClass = ClassSystem;
		e.illegal = 1'b1;
		return e;
	end
	e.aluOp = expectAluOp(i);
	e.imm = expectImm(i);
	e.rs1 = (op inside {OpLui, OpAuipc, OpJal}) ? 5'd0 : i[19:15];
	e.rs2 = (op inside {OpBranch, OpStore, OpReg}) ? i[24:20] : 5'd0;
	e.rd = (op inside {OpBranch, OpStore}) ? 5'd0 : i[11:7];
	e.regWrite = !(op inside {OpBranch, OpStore, OpFence, OpSystem});
	e.aluSrc = op inside {OpLui, OpAuipc, OpJal, OpJalr, OpLoad, OpStore, OpImm};
	e.memToReg = (op == OpLoad);
	e.memWrite = (op == OpStore);
	e.branch = (op == OpBranch);
	e.jump = (op == OpJal);
	e.jalr = (op == OpJalr);
	e.auipc = (op == OpAuipc);
	e.loadType = (op == OpLoad) ? ldTypes[f3] : LoadWordOrNone;
	e.storeMask = (op == OpStore) ? f3[1:0] + 2'd1 : 2'd0;
	case (op)
		OpBranch: e.instrClass = ClassBranch;
		OpLoad: e.instrClass = ClassLoad;
		OpStore: e.instrClass = ClassStore;
		OpFence, OpSystem: e.instrClass = ClassSystem;
		default: e.instrClass = ClassAlu;
	endcase
	return e;
endfunction

`endif

/* sim/decodeTb.sv */
module decodeTb;
	import decodePkg::*;
	`include "decodeExpect.svh"

	localparam int QueueDepth = 4;
	localparam int OutCredits = 2;
	localparam int HalfPeriod = 20;
	localparam int DriveDelay = 2;
	localparam int ResetCycles = 16;
	localparam logic [31:0] RandSeed = 32'h7fa4_35e0;

	typedef enum int {CreditsNow, CreditsHeld, CreditsRandom} creditModeT;

	logic       clk = 1'b0;
	logic       arstN;
	logic       instrValid;
	instrT      instr;
	logic       outCredit = 1'b0;
	logic       instrCredit;
	logic       decValid;
	aluOpT      decAluOp;
	wordT       decImm;
	regIdxT     decRs1;
	regIdxT     decRs2;
	regIdxT     decRd;
	logic       decRegWrite;
	logic       decAluSrc;
	logic       decMemToReg;
	logic       decMemWrite;
	logic       decBranch;
	logic       decJump;
	logic       decJalr;
	logic       decAuipc;
	loadTypeT   decLoadType;
	storeMaskT  decStoreMask;
	instrClassT decClass;
	logic       decIllegal;

	decodeEntryT expQ [$]; // expected words in send order
	int          sent;
	int          received;
	int          creditsBack; // instrCredit pulses seen
	int          outGiven;
	int          cycles;
	int          valueErrors;
	int          otherErrors;
	creditModeT  creditMode = CreditsNow;

	decodeTop #(.QueueDepth(QueueDepth), .OutCredits(OutCredits)) i_dut (.*);

	always #HalfPeriod clk = ~clk;

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////
	task automatic checkAluOp(input string name, input aluOpT expVal, input aluOpT actVal);
		if (actVal !== expVal) begin
			valueErrors++;
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, expVal, actVal);
		end
	endtask

	task automatic checkWord(input string name, input wordT expVal, input wordT actVal);
		if (actVal !== expVal) begin
			valueErrors++;
			$display("FAILED at %0t: %s expected %h got %h", $time, name, expVal, actVal);
		end
	endtask

	task automatic checkIdx(input string name, input regIdxT expVal, input regIdxT actVal);
		if (actVal !== expVal) begin
			valueErrors++;
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, expVal, actVal);
		end
	endtask

	task automatic checkFlag(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal) begin
			valueErrors++;
			$display("FAILED at %0t: %s expected %b got %b", $time, name, expVal, actVal);
		end
	endtask

	task automatic checkLoad(input string name, input loadTypeT expVal, input loadTypeT actVal);
		if (actVal !== expVal) begin
			valueErrors++;
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, expVal, actVal);
		end
	endtask

	task automatic checkMask(input string name, input storeMaskT expVal,
		input storeMaskT actVal);
		if (actVal !== expVal) begin
			valueErrors++;
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, expVal, actVal);
		end
	endtask

	task automatic checkClass(input string name, input instrClassT expVal,
		input instrClassT actVal);
		if (actVal !== expVal) begin
			valueErrors++;
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, expVal, actVal);
		end
	endtask

	task automatic checkEntry(input decodeEntryT e);
		checkAluOp("decAluOp", e.aluOp, decAluOp);
		checkWord("decImm", e.imm, decImm);
		checkIdx("decRs1", e.rs1, decRs1);
		checkIdx("decRs2", e.rs2, decRs2);
		checkIdx("decRd", e.rd, decRd);
		checkFlag("decRegWrite", e.regWrite, decRegWrite);
		checkFlag("decAluSrc", e.aluSrc, decAluSrc);
		checkFlag("decMemToReg", e.memToReg, decMemToReg);
		checkFlag("decMemWrite", e.memWrite, decMemWrite);
		checkFlag("decBranch", e.branch, decBranch);
		checkFlag("decJump", e.jump, decJump);
		checkFlag("decJalr", e.jalr, decJalr);
		checkFlag("decAuipc", e.auipc, decAuipc);
		checkLoad("decLoadType", e.loadType, decLoadType);
		checkMask("decStoreMask", e.storeMask, decStoreMask);
		checkClass("decClass", e.instrClass, decClass);
		checkFlag("decIllegal", e.illegal, decIllegal);
	endtask

	task automatic closeRun();
		$display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	endtask

	//////////////////////////////////////////////////
	// output monitor and watchdog
	//////////////////////////////////////////////////
	always @(negedge clk) begin
		cycles++;
		if (arstN) begin
			if (instrCredit)
				creditsBack++;
			if (decValid) begin
				if (received < expQ.size()) begin
					checkEntry(expQ[received]);
				end else begin
					otherErrors++;
					$display("%0t: decValid with no instruction outstanding", $time);
				end
				received++;
			end
		end
		if (cycles > 200 + 40 * sent) begin
			otherErrors++;
			$display("%0t: timeout after %0d cycles, %0d sent, %0d decoded", $time, cycles,
				sent, received);
			closeRun();
		end
	end

	// one output credit back per decoded word
	always @(posedge clk) begin
		#DriveDelay;
		outCredit = 1'b0;
		if (received > outGiven) begin
			case (creditMode)
				CreditsNow: outCredit = 1'b1;
				CreditsRandom: outCredit = (($urandom % 4) == 0);
				default: ;
			endcase
			if (outCredit)
				outGiven++;
		end
	end

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////
	function automatic int upstreamCredits();
		return 1 + creditsBack - sent;
	endfunction

	function automatic instrT makeInstr(logic [6:0] op, logic [2:0] f3, logic [6:0] f7);
		return {f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), op};
	endfunction

	function automatic instrT randomLegal();
		logic [6:0] ops [9];
		logic [2:0] f3;
		logic [6:0] f7;
		int         kind;
		ops = '{OpLui, OpAuipc, OpJal, OpJalr, OpBranch, OpLoad, OpStore, OpImm, OpReg};
		kind = int'($urandom % 11);
		f3 = 3'($urandom);
		f7 = 7'($urandom);
		case (kind)
			3: f3 = 3'b000;
			4: if (f3 inside {3'b010, 3'b011})
				f3 = 3'b000;
			5: if (f3 inside {3'b011, 3'b110, 3'b111})
				f3 = 3'b010;
			6: f3 = 3'($urandom % 3);
			7: if (f3 == 3'b001 || f3 == 3'b101)
				f7 = {1'b0, f7[5] & f3[2], 5'b0}; // srai only on 101
			8: f7 = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, f7[5], 5'b0} : 7'b0;
			9: return 32'h0ff0000f;
			10: return f7[0] ? 32'h00100073 : 32'h00000073;
			default: ;
		endcase
		return makeInstr(ops[kind], f3, f7);
	endfunction

	// called and returns at DriveDelay after a rising edge
	task automatic sendInstr(input instrT value);
		while (upstreamCredits() <= 0) begin
			@(posedge clk);
			#DriveDelay;
		end
		instrValid = 1'b1;
		instr = value;
		expQ.push_back(expectEntry(value));
		sent++;
		@(posedge clk);
		#DriveDelay;
		instrValid = 1'b0;
	endtask

	task automatic drainOutputs();
		while (received < sent || outGiven < received) begin
			@(posedge clk);
			#DriveDelay;
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////
	task automatic resetState();
		arstN = 1'b0;
		repeat (ResetCycles) begin
			@(negedge clk);
			checkFlag("decValid", 1'b0, decValid);
			checkFlag("instrCredit", 1'b0, instrCredit);
		end
		@(posedge clk);
		#DriveDelay;
		arstN = 1'b1;
		@(negedge clk);
		checkFlag("decValid", 1'b0, decValid);
		checkFlag("instrCredit", 1'b0, instrCredit);
		@(posedge clk);
		#DriveDelay;
	endtask

	task automatic perInstruction();
		logic [2:0] brF3 [6];
		logic [2:0] ldF3 [5];
		brF3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		ldF3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
		creditMode = CreditsNow;
		sendInstr(makeInstr(OpLui, 3'($urandom), 7'($urandom)));
		sendInstr(makeInstr(OpAuipc, 3'($urandom), 7'($urandom)));
		sendInstr(makeInstr(OpJal, 3'($urandom), 7'($urandom)));
		sendInstr(makeInstr(OpJalr, 3'b000, 7'($urandom)));
		foreach (brF3[k])
			sendInstr(makeInstr(OpBranch, brF3[k], 7'($urandom)));
		foreach (ldF3[k])
			sendInstr(makeInstr(OpLoad, ldF3[k], 7'($urandom)));
		for (int k = 0; k < 3; k++)
			sendInstr(makeInstr(OpStore, 3'(k), 7'($urandom)));
		for (int k = 0; k < 8; k++)
			sendInstr(makeInstr(OpImm, 3'(k), (k == 1 || k == 5) ? 7'b0 : 7'($urandom)));
		sendInstr(makeInstr(OpImm, 3'b101, 7'b0100000)); // srai
		for (int k = 0; k < 8; k++)
			sendInstr(makeInstr(OpReg, 3'(k), 7'b0));
		sendInstr(makeInstr(OpReg, 3'b000, 7'b0100000)); // sub
		sendInstr(makeInstr(OpReg, 3'b101, 7'b0100000)); // sra
		sendInstr(32'h0ff0000f);
		sendInstr(32'h00000073);
		sendInstr(32'h00100073);
		drainOutputs();
	endtask

	task automatic illegalEncodings();
		creditMode = CreditsNow;
		sendInstr(makeInstr(7'b1111111, 3'($urandom), 7'($urandom)));
		sendInstr(makeInstr(OpBranch, 3'b010, 7'($urandom)));
		sendInstr(makeInstr(OpLoad, 3'b011, 7'($urandom)));
		sendInstr(makeInstr(OpStore, 3'b100, 7'($urandom)));
		drainOutputs();
	endtask

	task automatic outputBackPressure();
		int base;
		int k;
		int idle;
		base = received;
		k = 0;
		idle = 0;
		creditMode = CreditsHeld;
		while (k < 10 && idle < 30) begin
			if (upstreamCredits() > 0) begin
				sendInstr(randomLegal());
				k++;
				idle = 0;
			end else begin
				@(posedge clk);
				#DriveDelay;
				idle++;
			end
		end
		if (k == 10) begin
			otherErrors++;
			$display("%0t: upstream never stalled while output credits were held", $time);
		end
		if (received - base > OutCredits) begin
			otherErrors++;
			$display("FAILED at %0t: decValid pulses while held expected at most %0d got %0d",
				$time, OutCredits, received - base);
		end
		creditMode = CreditsNow;
		while (k < 10) begin
			sendInstr(randomLegal());
			k++;
		end
		drainOutputs();
	endtask

	task automatic randomStream();
		creditMode = CreditsRandom;
		repeat (60)
			sendInstr(randomLegal());
		drainOutputs();
		if (creditsBack != sent) begin
			otherErrors++;
			$display("FAILED at %0t: instrCredit pulses expected %0d got %0d", $time, sent,
				creditsBack);
		end
	endtask

	initial begin
		void'($urandom(RandSeed));
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		resetState();
		perInstruction();
		illegalEncodings();
		outputBackPressure();
		randomStream();
		closeRun();
	end

endmodule

/* sim/decodeTb_properties.sv */
module decodeTbProperties #(
	parameter int LevelBits = 4,
	parameter int LevelMax = 2
) (
	input logic                 clk,
	input logic                 arstN,
	input logic                 push,
	input logic                 pop,
	input logic                 headValid,
	input logic [LevelBits-1:0] level
);

	popNeedsHead: assert property (@(posedge clk) disable iff (!arstN) pop |-> headValid)
		else $error("pop raised while headValid is low");

	// credit count or occupancy
	levelBounded: assert property (@(posedge clk) disable iff (!arstN)
		level <= LevelBits'(LevelMax))
		else $error("level %0d above limit %0d", level, LevelMax);

	noPushWhenFull: assert property (@(posedge clk) disable iff (!arstN)
		!(push && level == LevelBits'(LevelMax)))
		else $error("push while the level is at its limit");

endmodule

bind decodeQueue decodeTbProperties #(.LevelBits(CntBits), .LevelMax(QueueDepth)) i_queueProps (
	.clk(clk), .arstN(arstN), .push(push), .pop(pop), .headValid(headValid), .level(count)
);

// a returned credit raises the count like a push
bind issuePort decodeTbProperties #(
	.LevelBits(decodePkg::CreditBits),
	.LevelMax(OutCredits)
) i_outProps (
	.clk(clk), .arstN(arstN), .push(outCredit), .pop(pop), .headValid(headValid),
	.level(outCnt)
);

/* vlog.f */
+incdir+include
design/decodePkg.sv
design/ctrlDecoder.sv
design/decodeQueue.sv
design/issuePort.sv
design/decodeTop.sv
sim/decodeTb_properties.sv
sim/decodeTb.sv
